// ==== divPkg.sv ====
`default_nettype none

package divPkg;

    // Operand width of the divider.
    localparam int DataWidth = 32;

    // Step counter, one quotient bit per step.
    localparam int CountWidth = $clog2(DataWidth);

    localparam int TagWidth = 4;

    // Request buffer.
    localparam int FifoDepth    = 4;
    localparam int FifoPtrWidth = $clog2(FifoDepth);
    localparam int FifoCntWidth = $clog2(FifoDepth + 1); // Holds 0 to FifoDepth.

    // Divide request, 68 bits.
    typedef struct packed {
        logic [TagWidth-1:0]  tag;
        logic [DataWidth-1:0] dividend;
        logic [DataWidth-1:0] divisor;
    } divReq_t;

    // Divide response, 69 bits.
    typedef struct packed {
        logic [TagWidth-1:0]  tag;
        logic [DataWidth-1:0] quotient;
        logic [DataWidth-1:0] remainder;
        logic                 divByZero;   // Divisor was zero at load.
    } divRsp_t;

endpackage

`default_nettype wire

// ==== reqFifo.sv ====
`default_nettype none

module reqFifo import divPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    wrValid,
    input  divReq_t wrData,
    input  logic    pop,
    output divReq_t head,
    output logic    notEmpty,
    output logic    overflow
);

    divReq_t                 mem [FifoDepth];
    logic [FifoPtrWidth-1:0] rdPtr;
    logic [FifoPtrWidth-1:0] wrPtr;
    logic [FifoCntWidth-1:0] count;
    logic                    full;
    logic                    doPop;
    logic                    doWrite;

    // Wraps at FifoDepth, which need not be a power of two.
    function automatic logic [FifoPtrWidth-1:0] nextPtr(input logic [FifoPtrWidth-1:0] ptr);
        logic [FifoPtrWidth-1:0] result;
        if (ptr == FifoPtrWidth'(FifoDepth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign full     = (count == FifoCntWidth'(FifoDepth));
    assign notEmpty = (count != '0);
    assign doPop    = pop && notEmpty;
    assign doWrite  = wrValid && (!full || doPop); // A pop frees a slot on the same edge.

    // Oldest entry, read without a register stage.
    assign head = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
        end else begin
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (doWrite) begin
                wrPtr <= nextPtr(wrPtr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({doWrite, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither.
            endcase
        end
    end

    // Sticky, cleared only by reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (wrValid && !doWrite) begin
            overflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== divCore.sv ====
`default_nettype none

module divCore import divPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  divReq_t head,
    input  logic    notEmpty,
    output logic    pop,
    output logic    rspValid,
    output divRsp_t rsp
);

    logic [2*DataWidth-1:0] remReg;     // Partial remainder.
    logic [2*DataWidth-1:0] divReg;     // Divisor, shifted right each step.
    logic [DataWidth-1:0]   quotReg;
    logic [TagWidth-1:0]    tagReg;
    logic                   zeroReg;
    logic [CountWidth-1:0]  stepCnt;
    logic [CountWidth-1:0]  bitIdx;
    logic                   busy;
    logic                   lastStep;
    logic                   divGreater;
    logic [2*DataWidth-1:0] diff;

    // Take a new request only between operations.
    assign pop = !busy && notEmpty;

    // Compare and subtract for the current step.
    assign divGreater = (divReg > remReg);
    assign diff       = remReg - divReg;

    // Step 0 writes the MSB of the quotient.
    assign bitIdx   = CountWidth'(DataWidth - 1) - stepCnt;
    assign lastStep = (stepCnt == CountWidth'(DataWidth - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            stepCnt  <= '0;
            rspValid <= 1'b0;
        end else begin
            // One cycle strobe on the edge of the final step.
            rspValid <= busy && lastStep;
            if (pop) begin
                busy    <= 1'b1;
                stepCnt <= '0;
            end else if (busy) begin
                stepCnt <= stepCnt + 1'b1;
                if (lastStep) begin
                    busy <= 1'b0;  // Idle in the response cycle.
                end
            end
        end
    end

    // Load edge.
    always_ff @(posedge clk) begin
        if (pop) begin
            tagReg  <= head.tag;
            zeroReg <= (head.divisor == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            remReg <= {{DataWidth{1'b0}}, head.dividend};
            // Divisor aligned to bit 31 of the remainder for the first step.
            divReg <= {1'b0, head.divisor, {(DataWidth - 1){1'b0}}};
        end else if (busy) begin
            divReg <= {1'b0, divReg[2*DataWidth-1:1]};
            if (!divGreater) begin
                remReg <= diff;
            end
        end
    end

    // A zero divisor never compares greater, so every bit comes out set.
    always_ff @(posedge clk) begin
        if (busy) begin
            quotReg[bitIdx] <= !divGreater;
        end
    end

    assign rsp.tag       = tagReg;
    assign rsp.quotient  = quotReg;
    assign rsp.remainder = remReg[DataWidth-1:0];
    assign rsp.divByZero = zeroReg;

endmodule

`default_nettype wire

// ==== divUnit.sv ====
`default_nettype none

module divUnit import divPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reqValid,
    input  divReq_t req,
    output logic    rspValid,
    output divRsp_t rsp,
    output logic    overflow
);

    divReq_t head;
    logic    notEmpty;
    logic    pop;

    // Holds requests while the core is busy.
    reqFifo u_reqFifo (
        .clk      (clk),
        .rst      (rst),
        .wrValid  (reqValid),
        .wrData   (req),
        .pop      (pop),
        .head     (head),
        .notEmpty (notEmpty),
        .overflow (overflow)
    );

    // One request at a time, 33 cycles each.
    divCore u_divCore (
        .clk      (clk),
        .rst      (rst),
        .head     (head),
        .notEmpty (notEmpty),
        .pop      (pop),
        .rspValid (rspValid),
        .rsp      (rsp)
    );

endmodule

`default_nettype wire

// ==== divUnit_properties.sv ====
`default_nettype none

module divUnitProperties import divPkg::*; (
    input logic clk,
    input logic rst,
    input logic rspValid,
    input logic overflow
);

    timeunit 1ns;
    timeprecision 1ps;

    int sinceRsp;  // Edges since the last response strobe.

    always_ff @(posedge clk) begin
        if (rst) begin
            sinceRsp <= DataWidth;
        end else if (rspValid) begin
            sinceRsp <= 0;
        end else if (sinceRsp < 2 * DataWidth) begin
            sinceRsp <= sinceRsp + 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) rspValid |=> !rspValid)
        else $error("rspValid high in two consecutive cycles");

    // One load edge plus DataWidth step edges between strobes.
    assert property (@(posedge clk) disable iff (rst) rspValid |-> sinceRsp >= DataWidth)
        else $error("rspValid pulses closer than one full divide");

    assert property (@(posedge clk) !$past(rst) |-> !$fell(overflow))
        else $error("overflow fell outside reset");

    assert property (@(posedge clk) $past(rst) |-> !rspValid)
        else $error("rspValid high in the cycle after reset");

endmodule

bind divUnit divUnitProperties i_props (
    .clk      (clk),
    .rst      (rst),
    .rspValid (rspValid),
    .overflow (overflow)
);

`default_nettype wire

// ==== tb_divUnit.sv ====
`default_nettype none

module tb_divUnit import divPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumDirected    = 9;
    localparam int NumRandom      = 48;
    localparam int NumBurst       = 8;
    localparam int NumFinal       = 20;
    localparam int NumRequests    = 1 + NumDirected + NumRandom + NumBurst + NumFinal;
    localparam int WatchdogCycles = NumRequests * 40 + 200;

    logic    clk;
    logic    rst;
    logic    reqValid;
    divReq_t req;
    logic    rspValid;
    divRsp_t rsp;
    logic    overflow;

    divReq_t     expQ[$];              // Accepted requests, oldest first.
    logic [31:0] lfsrState = 32'hd6b4;
    logic        expOverflow;
    int          modelCount;           // FIFO entries after the last edge.
    int          modelRemain;          // Step edges left in the core.
    int          cycleCnt = 0;
    int          lastRspCycle = 0;
    int          errorCount = 0;
    int          issued = 0;
    int          accepted = 0;
    int          dropped = 0;
    int          rspCount = 0;

    divUnit i_dut (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .rspValid (rspValid),
        .rsp      (rsp),
        .overflow (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ 32'h8020_0003;
        end
        return stepped;
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    function automatic divReq_t randomReq();
        divReq_t    r;
        logic [2:0] kind;
        r.tag      = TagWidth'(randBits(TagWidth));
        r.dividend = randBits(DataWidth);
        r.divisor  = randBits(DataWidth);
        kind       = 3'(randBits(3));
        case (kind)
            3'd0:    r.divisor = '0;
            3'd1:    r.divisor = 32'd1;
            3'd2:    r.divisor = r.dividend;
            3'd3:    r.divisor = randBits(8);
            3'd4:    r.dividend = randBits(8);  // Mostly below the divisor.
            default: ;
        endcase
        return r;
    endfunction

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("[ERROR] %s: got %h expected %h", name, got, expected);
        errorCount++;
    endtask

    task automatic checkOutputs();
        divReq_t     expReq;
        logic [31:0] expQuot;
        logic [31:0] expRem;
        logic        expZero;
        if (overflow !== expOverflow) begin
            reportValue("overflow", 32'(overflow), 32'(expOverflow));
        end
        if (rspValid === 1'b1) begin
            rspCount++;
            lastRspCycle = cycleCnt;
            if (expQ.size() == 0) begin
                $display("Response with tag %h arrived while no request was pending", rsp.tag);
                errorCount++;
            end else begin
                expReq = expQ.pop_front();
                if (expReq.divisor == '0) begin
                    expQuot = '1;
                    expRem  = expReq.dividend;
                    expZero = 1'b1;
                end else begin
                    expQuot = expReq.dividend / expReq.divisor;
                    expRem  = expReq.dividend % expReq.divisor;
                    expZero = 1'b0;
                end
                if (rsp.tag !== expReq.tag) begin
                    reportValue("rsp.tag", 32'(rsp.tag), 32'(expReq.tag));
                end
                if (rsp.quotient !== expQuot) begin
                    reportValue("rsp.quotient", rsp.quotient, expQuot);
                end
                if (rsp.remainder !== expRem) begin
                    reportValue("rsp.remainder", rsp.remainder, expRem);
                end
                if (rsp.divByZero !== expZero) begin
                    reportValue("rsp.divByZero", 32'(rsp.divByZero), 32'(expZero));
                end
                if (!expZero && rsp.remainder >= expReq.divisor) begin
                    reportValue("rsp.remainder", rsp.remainder, expReq.divisor);
                end
            end
        end
    endtask

    // Checks the last edge, then drives the next one and advances the model.
    task automatic tick(input logic valid, input divReq_t r);
        logic modelPop;
        logic accept;
        @(negedge clk);
        checkOutputs();
        modelPop = (modelRemain == 0) && (modelCount != 0);
        accept   = valid && ((modelCount < FifoDepth) || modelPop);
        if (valid) begin
            issued++;
            if (accept) begin
                expQ.push_back(r);
                accepted++;
            end else begin
                expOverflow = 1'b1;
                dropped++;
            end
        end
        if (modelPop) begin
            modelRemain = DataWidth;
        end else if (modelRemain != 0) begin
            modelRemain--;
        end
        if (accept && !modelPop) begin
            modelCount++;
        end else if (!accept && modelPop) begin
            modelCount--;
        end
        reqValid = valid;
        req      = r;
    endtask

    task automatic drain();
        while (expQ.size() != 0) begin
            tick(1'b0, '0);
        end
        repeat (4) begin
            tick(1'b0, '0);  // Catches stray strobes.
        end
    endtask

    task automatic applyReset();
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        repeat (5) @(negedge clk);
        rst         = 1'b0;
        modelCount  = 0;
        modelRemain = 0;
        expOverflow = 1'b0;
    endtask

    task automatic sendDirected(input logic [31:0] dividend, input logic [31:0] divisor);
        divReq_t r;
        r.tag      = TagWidth'(randBits(TagWidth));
        r.dividend = dividend;
        r.divisor  = divisor;
        tick(1'b1, r);
        drain();
    endtask

    // Bursts of one to four requests with gaps of up to 31 cycles.
    task automatic runRandom(input int count);
        int sent;
        int burst;
        int gap;
        sent = 0;
        while (sent < count) begin
            burst = int'(randBits(2)) + 1;
            for (int i = 0; i < burst && sent < count; i++) begin
                tick(1'b1, randomReq());
                sent++;
            end
            gap = int'(randBits(5));
            repeat (gap) begin
                tick(1'b0, '0);
            end
        end
        drain();
    endtask

    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout after %0d cycles, %0d responses still missing",
                 WatchdogCycles, expQ.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int wrEdge;
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        applyReset();

        tick(1'b1, randomReq());
        wrEdge = cycleCnt + 1;          // Edge that writes the request.
        drain();
        if (lastRspCycle - wrEdge != DataWidth + 1) begin
            $display("Isolated request took %0d cycles instead of %0d",
                     lastRspCycle - wrEdge, DataWidth + 1);
            errorCount++;
        end

        sendDirected(32'd5, 32'd7);
        sendDirected(32'd9, 32'd9);
        sendDirected(32'h1234_5678, 32'd1);
        sendDirected(32'hffff_ffff, 32'hffff_ffff);
        sendDirected(32'hffff_ffff, 32'd1);
        sendDirected(32'd1, 32'hffff_ffff);
        sendDirected(32'd0, 32'd0);
        sendDirected(32'hdead_beef, 32'd0);
        sendDirected(32'd0, 32'd5);

        runRandom(NumRandom);

        // Back to back, more than the FIFO holds while the core is busy.
        repeat (NumBurst) begin
            tick(1'b1, randomReq());
        end
        tick(1'b0, '0);
        if (overflow !== 1'b1) begin
            $display("Overflow flag did not rise after a burst of %0d requests", NumBurst);
            errorCount++;
        end
        drain();

        applyReset();
        if (overflow !== 1'b0) begin
            reportValue("overflow", 32'(overflow), 32'd0);
        end
        runRandom(NumFinal);

        if (rspCount != accepted) begin
            $display("Got %0d responses for %0d accepted requests", rspCount, accepted);
            errorCount++;
        end
        $display("Errors %0d, issued %0d, accepted %0d, dropped %0d, responses %0d",
                 errorCount, issued, accepted, dropped, rspCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
divPkg.sv
reqFifo.sv
divCore.sv
divUnit.sv
divUnit_properties.sv
tb_divUnit.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the divider testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_divUnit -f vlog.f -o simv

out=$(./obj_dir/simv 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
